// File: source/exec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DATA_W must be 2*HALF_W, and NUM_LANES must be 2**LANE_IDX_W
// flags are {carry, overflow, negative, zero} from the top bit down
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package exec_pkg;

  localparam int DATA_W     = 64;
  localparam int HALF_W     = 32; // split point of the carry chain
  localparam int TAG_W      = 4;
  localparam int NUM_LANES  = 4;
  localparam int LANE_IDX_W = 2;

  // bit positions inside flags_t
  localparam int FL_C = 3;
  localparam int FL_V = 2;
  localparam int FL_N = 1;
  localparam int FL_Z = 0;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [3:0]        flags_t;
  typedef logic [3:0]        cond_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_shl,
    op_shr,
    op_sar,
    op_sxt
  } alu_op_t;

  typedef enum logic [1:0] {
    sxt_byte,
    sxt_half,
    sxt_word
  } sxt_size_t;

  typedef struct packed {
    alu_op_t   op;
    cond_t     cond;
    sxt_size_t sxt;      // only read by op_sxt
    flags_t    flags_in;
    data_t     a;
    data_t     b;
    tag_t      tag;
  } exec_req_t;

  typedef struct packed {
    data_t  result;
    flags_t flags;
    logic   cond_taken;
    tag_t   tag;
  } exec_rsp_t;

endpackage

// File: source/flag_cond_eval.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// purely combinational, code 14 always and code 15 never
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module flag_cond_eval (
  input  exec_pkg::cond_t  cond,
  input  exec_pkg::flags_t flags,
  output logic             taken
);
  import exec_pkg::*;

  logic fc;
  logic fv;
  logic fn;
  logic fz;

  assign fc = flags[FL_C];
  assign fv = flags[FL_V];
  assign fn = flags[FL_N];
  assign fz = flags[FL_Z];

  always_comb begin
    case (cond)
      4'd0:    taken = fz;
      4'd1:    taken = ~fz;
      4'd2:    taken = fc;
      4'd3:    taken = ~fc;
      4'd4:    taken = fn;
      4'd5:    taken = ~fn;
      4'd6:    taken = fv;
      4'd7:    taken = ~fv;
      4'd8:    taken = fc & ~fz;         // unsigned higher
      4'd9:    taken = ~fc | fz;         // lower or same
      4'd10:   taken = (fn == fv);       // signed ge
      4'd11:   taken = (fn != fv);
      4'd12:   taken = (fn == fv) & ~fz; // signed gt
      4'd13:   taken = (fn != fv) | fz;
      4'd14:   taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: source/alu_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two items in flight at most, result leaves 2 edges after accept
// shift counts use the low 6 bits of b only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_lane (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  output logic                req_ready,
  input  exec_pkg::exec_req_t req,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output exec_pkg::exec_rsp_t rsp
);
  import exec_pkg::*;

  typedef struct packed {
    alu_op_t           op;
    sxt_size_t         sxt;
    logic              taken;
    flags_t            flags_in;
    data_t             a;
    data_t             b;
    logic [HALF_W-1:0] lo;
    logic              carry; // out of the low half
    tag_t              tag;
  } stage1_t;

  logic              taken;
  logic              lo_sub;
  logic [HALF_W:0]   lo_sum;
  data_t             lo_misc;
  stage1_t           s1_d;
  stage1_t           s1_q;
  logic              s1_valid;
  logic              out_free;
  logic              hi_sub;
  logic [HALF_W:0]   hi_sum;
  data_t             hi_misc;
  logic [HALF_W-1:0] hi;
  data_t             res;
  flags_t            flags;
  exec_rsp_t         rsp_q;

  // everything that is not add/sub, full width
  function automatic data_t misc_res(alu_op_t op, sxt_size_t sxt, data_t a, data_t b);
    logic [$clog2(DATA_W)-1:0] sh;
    sh = b[$clog2(DATA_W)-1:0];
    case (op)
      op_and: misc_res = a & b;
      op_or:  misc_res = a | b;
      op_xor: misc_res = a ^ b;
      op_shl: misc_res = a << sh;
      op_shr: misc_res = a >> sh;
      op_sar: misc_res = data_t'($signed(a) >>> sh);
      op_sxt: begin
        case (sxt)
          sxt_byte: misc_res = {{(DATA_W-8){a[7]}}, a[7:0]};
          sxt_half: misc_res = {{(DATA_W-16){a[15]}}, a[15:0]};
          default:  misc_res = {{(DATA_W-32){a[31]}}, a[31:0]};
        endcase
      end
      default: misc_res = '0;
    endcase
  endfunction

  flag_cond_eval cond_i (
    .cond  (req.cond),
    .flags (req.flags_in),
    .taken (taken)
  );

  // stage 1: condition, low half, low carry
  always_comb begin
    lo_sub = (req.op == op_sub);
    lo_sum = {1'b0, req.a[HALF_W-1:0]}
           + {1'b0, req.b[HALF_W-1:0] ^ {HALF_W{lo_sub}}}
           + (HALF_W+1)'(lo_sub); // +1 completes a - b
    lo_misc = misc_res(req.op, req.sxt, req.a, req.b);

    s1_d.op       = req.op;
    s1_d.sxt      = req.sxt;
    s1_d.taken    = taken;
    s1_d.flags_in = req.flags_in;
    s1_d.a        = req.a;
    s1_d.b        = req.b;
    s1_d.carry    = lo_sum[HALF_W];
    s1_d.tag      = req.tag;
    if (!taken)
      s1_d.lo = req.a[HALF_W-1:0];
    else if (req.op == op_add || req.op == op_sub)
      s1_d.lo = lo_sum[HALF_W-1:0];
    else
      s1_d.lo = lo_misc[HALF_W-1:0];
  end

  // stage 2: high half on the registered carry, then flags
  always_comb begin
    hi_sub = (s1_q.op == op_sub);
    hi_sum = {1'b0, s1_q.a[DATA_W-1:HALF_W]}
           + {1'b0, s1_q.b[DATA_W-1:HALF_W] ^ {HALF_W{hi_sub}}}
           + (HALF_W+1)'(s1_q.carry);
    hi_misc = misc_res(s1_q.op, s1_q.sxt, s1_q.a, s1_q.b);

    if (!s1_q.taken)
      hi = s1_q.a[DATA_W-1:HALF_W];
    else if (s1_q.op == op_add || hi_sub)
      hi = hi_sum[HALF_W-1:0];
    else
      hi = hi_misc[DATA_W-1:HALF_W];
    res = {hi, s1_q.lo};

    flags       = '0;
    flags[FL_N] = res[DATA_W-1];
    flags[FL_Z] = ~|res;
    if (s1_q.op == op_add) begin
      flags[FL_C] = hi_sum[HALF_W];
      flags[FL_V] = (s1_q.a[DATA_W-1] == s1_q.b[DATA_W-1]) &&
                    (res[DATA_W-1] != s1_q.a[DATA_W-1]);
    end else if (hi_sub) begin
      flags[FL_C] = hi_sum[HALF_W]; // set means no borrow
      flags[FL_V] = (s1_q.a[DATA_W-1] != s1_q.b[DATA_W-1]) &&
                    (res[DATA_W-1] != s1_q.a[DATA_W-1]);
    end
    if (!s1_q.taken)
      flags = s1_q.flags_in;
  end

  assign out_free  = ~rsp_valid | rsp_ready;
  assign req_ready = ~s1_valid | out_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (req_ready)
        s1_valid <= req_valid;
      if (out_free)
        rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready && req_valid)
      s1_q <= s1_d;
    if (out_free && s1_valid) begin // output holding register
      rsp_q.result     <= res;
      rsp_q.flags      <= flags;
      rsp_q.cond_taken <= s1_q.taken;
      rsp_q.tag        <= s1_q.tag;
    end
  end

  assign rsp = rsp_q;

endmodule

// File: source/issue_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational, lowest free lane wins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_dispatch (
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [exec_pkg::NUM_LANES-1:0] lane_ready,
  output logic [exec_pkg::NUM_LANES-1:0] lane_valid
);
  import exec_pkg::*;

  logic found;

  always_comb begin
    lane_valid = '0;
    found      = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_ready[i] && !found) begin
        lane_valid[i] = in_valid;
        found         = 1'b1;
      end
    end
  end

  assign in_ready = |lane_ready; // same as found

endmodule

// File: source/result_collect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered output adds one cycle; pointer wrap needs a power-of-two lane count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_collect (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                [exec_pkg::NUM_LANES-1:0] rsp_valid,
  output logic                [exec_pkg::NUM_LANES-1:0] rsp_ready,
  input  exec_pkg::exec_rsp_t [exec_pkg::NUM_LANES-1:0] rsp_in,
  output logic                                          out_valid,
  input  logic                                          out_ready,
  output exec_pkg::exec_rsp_t                           out_rsp
);
  import exec_pkg::*;

  logic [LANE_IDX_W-1:0] rr_ptr;
  logic [LANE_IDX_W-1:0] scan_idx;
  logic [LANE_IDX_W-1:0] grant_idx;
  logic                  grant_any;
  logic [NUM_LANES-1:0]  grant;
  logic                  slot_free;

  assign slot_free = ~out_valid | out_ready;

  // first valid lane at or after the pointer
  always_comb begin
    grant_any = 1'b0;
    grant_idx = '0;
    scan_idx  = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      scan_idx = rr_ptr + LANE_IDX_W'(k);
      if (!grant_any && rsp_valid[scan_idx]) begin
        grant_any = 1'b1;
        grant_idx = scan_idx;
      end
    end
    grant = NUM_LANES'(grant_any) << grant_idx;
  end

  assign rsp_ready = grant & {NUM_LANES{slot_free}};

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rr_ptr    <= '0;
    end else if (slot_free) begin
      out_valid <= grant_any;
      if (grant_any)
        rr_ptr <= grant_idx + 1'b1; // lane after the winner
    end
  end

  // held while out_ready is low
  always_ff @(posedge clk) begin
    if (slot_free && grant_any)
      out_rsp <= rsp_in[grant_idx];
  end

endmodule

// File: source/alu_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// responses leave out of order, match them by tag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_cluster (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::exec_req_t in_req,
  output logic                out_valid,
  input  logic                out_ready,
  output exec_pkg::exec_rsp_t out_rsp
);
  import exec_pkg::*;

  logic      [NUM_LANES-1:0] lane_valid;
  logic      [NUM_LANES-1:0] lane_ready;
  logic      [NUM_LANES-1:0] rsp_valid;
  logic      [NUM_LANES-1:0] rsp_ready;
  exec_rsp_t [NUM_LANES-1:0] lane_rsp;

  issue_dispatch dispatch_i (
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .lane_ready (lane_ready),
    .lane_valid (lane_valid)
  );

  // request bus is shared, only lane_valid is steered
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    alu_lane lane_i (
      .clk       (clk),
      .rst       (rst),
      .req_valid (lane_valid[g]),
      .req_ready (lane_ready[g]),
      .req       (in_req),
      .rsp_valid (rsp_valid[g]),
      .rsp_ready (rsp_ready[g]),
      .rsp       (lane_rsp[g])
    );
  end

  result_collect collect_i (
    .clk       (clk),
    .rst       (rst),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_in    (lane_rsp),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

endmodule

// File: include/tb_vectors.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// included inside the testbench module after the exec_pkg import
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct {
  alu_op_t   op;
  cond_t     cond;
  sxt_size_t sxt;
  flags_t    fin;
  data_t     a;
  data_t     b;
  data_t     res;  // expected result
  flags_t    fl;   // expected {c, v, n, z}
  logic      tk;   // expected cond_taken
} vec_t;

vec_t vecs[64];
int   num_vecs = 0;

task automatic add_vec(alu_op_t op, int cond, sxt_size_t sxt, flags_t fin,
                       data_t a, data_t b, data_t res, flags_t fl, logic tk);
  vecs[num_vecs] = '{op, cond_t'(cond), sxt, fin, a, b, res, fl, tk};
  num_vecs++;
endtask

task automatic load_vectors();
  // op, cond, sxt, flags_in, a, b, result, flags, taken
  // add and sub across the 32-bit split
  add_vec(op_add, 14, sxt_byte, 4'h0, 64'hffffffff, 64'h1, 64'h100000000, 4'h0, 1'b1);
  add_vec(op_add, 14, sxt_byte, 4'h0, '1, 64'h1, 64'h0, 4'h9, 1'b1);
  add_vec(op_add, 14, sxt_byte, 4'h0, 64'h7fffffffffffffff, 64'h1, 64'h8000000000000000,
          4'h6, 1'b1);
  add_vec(op_sub, 14, sxt_byte, 4'h0, 64'h100000000, 64'h1, 64'hffffffff, 4'h8, 1'b1);
  add_vec(op_sub, 14, sxt_byte, 4'h0, 64'h0, 64'h1, '1, 4'h2, 1'b1);
  add_vec(op_sub, 14, sxt_byte, 4'h0, 64'h8000000000000000, 64'h1, 64'h7fffffffffffffff,
          4'hc, 1'b1);
  add_vec(op_sub, 14, sxt_byte, 4'h0, 64'h5, 64'h5, 64'h0, 4'h9, 1'b1);
  // logic ops and sign extension
  add_vec(op_and, 14, sxt_byte, 4'h0, 64'hf0f0f0f00f0f0f0f, 64'hff00ff00ff00ff00,
          64'hf000f0000f000f00, 4'h2, 1'b1);
  add_vec(op_or, 14, sxt_byte, 4'h0, 64'hf0f0f0f00f0f0f0f, 64'hff00ff00ff00ff00,
          64'hfff0fff0ff0fff0f, 4'h2, 1'b1);
  add_vec(op_xor, 14, sxt_byte, 4'h0, 64'hf0f0f0f00f0f0f0f, 64'hff00ff00ff00ff00,
          64'h0ff00ff0f00ff00f, 4'h0, 1'b1);
  add_vec(op_xor, 14, sxt_byte, 4'h0, 64'h123456789abcdef0, 64'h123456789abcdef0, 64'h0,
          4'h1, 1'b1);
  add_vec(op_sxt, 14, sxt_byte, 4'h0, 64'h80, 64'h0, 64'hffffffffffffff80, 4'h2, 1'b1);
  add_vec(op_sxt, 14, sxt_half, 4'h0, 64'h1234000000007fff, 64'h0, 64'h7fff, 4'h0, 1'b1);
  add_vec(op_sxt, 14, sxt_word, 4'h0, 64'h80000001, 64'h0, 64'hffffffff80000001, 4'h2, 1'b1);
  // shifts of 0x8000_0000_0000_0001
  add_vec(op_shl, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd0, 64'h8000000000000001,
          4'h2, 1'b1);
  add_vec(op_shl, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd31, 64'h80000000, 4'h0, 1'b1);
  add_vec(op_shl, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd32, 64'h100000000, 4'h0, 1'b1);
  add_vec(op_shl, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd63, 64'h8000000000000000,
          4'h2, 1'b1);
  add_vec(op_shr, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd0, 64'h8000000000000001,
          4'h2, 1'b1);
  add_vec(op_shr, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd31, 64'h100000000, 4'h0, 1'b1);
  add_vec(op_shr, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd32, 64'h80000000, 4'h0, 1'b1);
  add_vec(op_shr, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd63, 64'h1, 4'h0, 1'b1);
  add_vec(op_sar, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd0, 64'h8000000000000001,
          4'h2, 1'b1);
  add_vec(op_sar, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd31, 64'hffffffff00000000,
          4'h2, 1'b1);
  add_vec(op_sar, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd32, 64'hffffffff80000000,
          4'h2, 1'b1);
  add_vec(op_sar, 14, sxt_byte, 4'h0, 64'h8000000000000001, 64'd63, '1, 4'h2, 1'b1);
  // all condition codes on 0x10 + 0x20
  add_vec(op_add, 0, sxt_byte, 4'h1, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 1, sxt_byte, 4'h1, 64'h10, 64'h20, 64'h10, 4'h1, 1'b0);
  add_vec(op_add, 2, sxt_byte, 4'h8, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 3, sxt_byte, 4'h8, 64'h10, 64'h20, 64'h10, 4'h8, 1'b0);
  add_vec(op_add, 4, sxt_byte, 4'h0, 64'h10, 64'h20, 64'h10, 4'h0, 1'b0);
  add_vec(op_add, 5, sxt_byte, 4'h0, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 6, sxt_byte, 4'h4, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 7, sxt_byte, 4'h4, 64'h10, 64'h20, 64'h10, 4'h4, 1'b0);
  add_vec(op_add, 8, sxt_byte, 4'h9, 64'h10, 64'h20, 64'h10, 4'h9, 1'b0);
  add_vec(op_add, 9, sxt_byte, 4'h9, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 10, sxt_byte, 4'h6, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 11, sxt_byte, 4'h6, 64'h10, 64'h20, 64'h10, 4'h6, 1'b0);
  add_vec(op_add, 12, sxt_byte, 4'h2, 64'h10, 64'h20, 64'h10, 4'h2, 1'b0);
  add_vec(op_add, 13, sxt_byte, 4'h2, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 14, sxt_byte, 4'hf, 64'h10, 64'h20, 64'h30, 4'h0, 1'b1);
  add_vec(op_add, 15, sxt_byte, 4'h0, 64'h10, 64'h20, 64'h10, 4'h0, 1'b0);
  // false condition keeps the upper half of a too
  add_vec(op_add, 15, sxt_byte, 4'h5, 64'h123456789abcdef0, 64'h1111111100000000,
          64'h123456789abcdef0, 4'h5, 1'b0);
endtask

`endif

// File: dv/tb_alu_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table runs twice, second pass under random out_ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_alu_cluster;
  import exec_pkg::*;

  `include "tb_vectors.svh"

  localparam int TIMEOUT = 500; // cycles per wait

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  exec_req_t in_req;
  logic      out_valid;
  logic      out_ready;
  exec_rsp_t out_rsp;

  exec_rsp_t   exp_rsp [16]; // indexed by tag
  logic [15:0] pending;
  int          seed;
  logic        rand_ready;
  int          got;
  logic        hold_chk;
  exec_rsp_t   held;

  alu_cluster dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    if (rand_ready)
      out_ready <= 1'($random(seed)); // about half the cycles stall
  end

  // response monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (hold_chk) begin
        check_value("out_valid held", 128'(1'b1), 128'(out_valid));
        check_value("out_rsp held", 128'(held), 128'(out_rsp));
      end
      hold_chk = out_valid && !out_ready;
      held     = out_rsp;
      if (out_valid && out_ready) begin
        if (!pending[out_rsp.tag])
          report_failure("response arrived with an unknown or repeated tag");
        check_value($sformatf("tag %0d result", out_rsp.tag),
                    128'(exp_rsp[out_rsp.tag].result), 128'(out_rsp.result));
        check_value($sformatf("tag %0d flags", out_rsp.tag),
                    128'(exp_rsp[out_rsp.tag].flags), 128'(out_rsp.flags));
        check_value($sformatf("tag %0d cond_taken", out_rsp.tag),
                    128'(exp_rsp[out_rsp.tag].cond_taken), 128'(out_rsp.cond_taken));
        pending[out_rsp.tag] = 1'b0;
        got++;
      end
    end
  end

  // called right after a rising edge; returns right after the accepting edge
  task automatic send_row(input int i);
    exec_req_t r;
    tag_t      tag;
    int        cnt;
    logic      acc;
    tag = tag_t'(i % 16);
    cnt = 0;
    if (pending[tag]) begin
      in_valid <= 1'b0;
      while (pending[tag]) begin
        @(posedge clk);
        cnt++;
        if (cnt > TIMEOUT)
          report_failure("timed out waiting for a tag to be released");
      end
    end
    r          = '{vecs[i].op, vecs[i].cond, vecs[i].sxt, vecs[i].fin,
                   vecs[i].a, vecs[i].b, tag};
    exp_rsp[tag] = '{vecs[i].res, vecs[i].fl, vecs[i].tk, tag};
    pending[tag] = 1'b1;
    in_valid <= 1'b1;
    in_req   <= r;
    cnt = 0;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = in_ready;
      @(posedge clk);
      cnt++;
      if (cnt > TIMEOUT)
        report_failure("timed out waiting for in_ready");
    end
  endtask

  initial begin
    int cnt;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_req     = '0;
    out_ready  = 1'b0;
    rand_ready = 1'b0;
    seed       = 77153;
    pending    = '0;
    got        = 0;
    hold_chk   = 1'b0;
    load_vectors();

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("out_valid after reset", 128'(1'b0), 128'(out_valid));
    check_value("in_ready after reset", 128'(1'b1), 128'(in_ready));
    @(posedge clk);

    out_ready <= 1'b1;
    for (int i = 0; i < num_vecs; i++)
      send_row(i);
    rand_ready <= 1'b1;
    for (int i = 0; i < num_vecs; i++)
      send_row(i);
    in_valid <= 1'b0;

    cnt = 0;
    while (got < 2 * num_vecs) begin
      @(posedge clk);
      cnt++;
      if (cnt > TIMEOUT)
        report_failure("timed out waiting for the last responses");
    end
    repeat (4) @(posedge clk);

    if (got != 2 * num_vecs || pending != '0) begin
      $display("response count %0d does not match %0d requests", got, 2 * num_vecs);
      $display("*** FAILED ***");
      $fatal(1);
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+include
source/exec_pkg.sv
source/flag_cond_eval.sv
source/alu_lane.sv
source/issue_dispatch.sv
source/result_collect.sv
source/alu_cluster.sv
dv/tb_alu_cluster.sv

// File: run_sim.sh
#!/bin/bash
# compile and run the ALU cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  -f flist.f \
  --top-module tb_alu_cluster

# the simulator may exit non-zero on failure; the log decides
./obj_dir/Vtb_alu_cluster > sim.log 2>&1 || true
cat sim.log

if grep -q -F "*** FAILED ***" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q -F "*** PASSED ***" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
